// ==== verilog/bp_stream_pkg.sv ====
////////////////////////////////////////////////////////////
// stream output package
// widths, message type and size encodings, the stream
// header and the run-time stream configuration
////////////////////////////////////////////////////////////

package bp_stream_pkg;

  // FSM side word and output side beat widths
  localparam int data_width_lp  = 64;
  localparam int fill_width_lp  = 128;
  // a cache block is the largest message the FSM can stream
  localparam int block_width_lp = 512;
  localparam int words_lp       = block_width_lp / data_width_lp;
  localparam int cnt_width_lp   = $clog2(words_lp);
  localparam int paddr_width_lp = 16;

  // the encoded value doubles as the bit index into both stream masks
  typedef enum logic [1:0]
  {
    e_rd    = 2'd0,
    e_wr    = 2'd1,
    e_uc_rd = 2'd2,
    e_uc_wr = 2'd3
  } msg_type_e;

  // log2 of the message size in bytes
  typedef enum logic [2:0]
  {
    e_size_1  = 3'd0,
    e_size_2  = 3'd1,
    e_size_4  = 3'd2,
    e_size_8  = 3'd3,
    e_size_16 = 3'd4,
    e_size_32 = 3'd5,
    e_size_64 = 3'd6
  } msg_size_e;

  typedef struct packed
  {
    msg_type_e                 msg_type;
    msg_size_e                 size;
    logic [paddr_width_lp-1:0] addr;
  } stream_header_s;

  // one bit per message type in each mask
  typedef struct packed
  {
    logic [3:0] msg_stream_mask;
    logic [3:0] fsm_stream_mask;
  } stream_cfg_s;

  // writes pack on the output, reads and writes stream on the FSM side
  localparam stream_cfg_s cfg_reset_lp = '{
    msg_stream_mask: 4'b1010,
    fsm_stream_mask: 4'b0011
  };

endpackage

// ==== verilog/bp_stream_cfg_regs.sv ====
////////////////////////////////////////////////////////////
// stream configuration register
// holds the msg and fsm stream masks, loaded on a strobe
////////////////////////////////////////////////////////////

module bp_stream_cfg_regs
  import bp_stream_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,

  // write strobe and new mask values
  input  logic        cfg_w_v_i,
  input  stream_cfg_s cfg_i,

  // current masks, steering the pump
  output stream_cfg_s cfg_o
);

  stream_cfg_s cfg_r;

  // the new value shows up on cfg_o the cycle after the strobe
  // software only writes here while no message is in flight
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      cfg_r <= cfg_reset_lp;
    else if (cfg_w_v_i)
      cfg_r <= cfg_i;
  end

  assign cfg_o = cfg_r;

endmodule

// ==== verilog/bp_stream_pump_control.sv ====
////////////////////////////////////////////////////////////
// stream pump control
// counts FSM beats of a message and derives the effective
// address, first, last and critical flags of each beat
////////////////////////////////////////////////////////////

module bp_stream_pump_control
  import bp_stream_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,

  // header is held by the FSM for the whole message
  input  stream_header_s            header_i,
  // one pulse per beat taken from the FSM
  input  logic                      ack_i,

  output logic [paddr_width_lp-1:0] addr_o,
  output logic                      first_o,
  output logic                      last_o,
  output logic                      critical_o
);

  logic [cnt_width_lp-1:0]   cnt_r;
  logic [cnt_width_lp-1:0]   last_cnt;
  logic [cnt_width_lp-1:0]   critical_cnt;
  logic [paddr_width_lp-1:0] size_mask;
  logic [paddr_width_lp-1:0] base_addr;

  // index of the final beat, one beat per 8 bytes and never fewer than one
  always_comb
  begin
    case (header_i.size)
      e_size_16: last_cnt = cnt_width_lp'(1);
      e_size_32: last_cnt = cnt_width_lp'(3);
      e_size_64: last_cnt = cnt_width_lp'(words_lp - 1);
      default:   last_cnt = '0;
    endcase
  end

  // the counter wraps back to zero once the last beat is acknowledged
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      cnt_r <= '0;
    else if (ack_i)
    begin
      if (cnt_r == last_cnt)
        cnt_r <= '0;
      else
        cnt_r <= cnt_r + 1'b1;
    end
  end

  // align the header address down to the message size
  assign size_mask = (paddr_width_lp'(1) << header_i.size) - 1'b1;
  assign base_addr = header_i.addr & ~size_mask;

  // each beat moves the address up by one 64-bit word
  assign addr_o = base_addr + {{(paddr_width_lp - cnt_width_lp - 3){1'b0}}, cnt_r, 3'b000};

  // the beat count is a power of two, so masking is the modulo
  assign critical_cnt = header_i.addr[5:3] & last_cnt;

  assign first_o    = (cnt_r == '0);
  assign last_o     = (cnt_r == last_cnt);
  assign critical_o = (cnt_r == critical_cnt);

endmodule

// ==== verilog/bp_stream_gearbox.sv ====
////////////////////////////////////////////////////////////
// stream gearbox
// packs pairs of 64-bit FSM words into 128-bit output beats
// for packing types, zero-extends single words otherwise
////////////////////////////////////////////////////////////

module bp_stream_gearbox
  import bp_stream_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     arst_n_i,

  // narrow side, one FSM word per beat
  input  stream_header_s           msg_header_i,
  input  logic [data_width_lp-1:0] msg_data_i,
  input  logic                     msg_v_i,
  // msg stream mask bit of this message type
  input  logic                     pack_i,
  // the word on msg_data_i is the last of its message
  input  logic                     last_i,
  output logic                     msg_ready_and_o,

  // wide side toward the sink
  output stream_header_s           msg_header_o,
  output logic [fill_width_lp-1:0] msg_data_o,
  output logic                     msg_v_o,
  input  logic                     msg_ready_and_i
);

  logic                     hold_v_r;
  logic [data_width_lp-1:0] hold_data_r;
  logic                     hold_load;
  logic                     hold_clear;

  // header travels with every beat, unchanged
  assign msg_header_o = msg_header_i;

  always_comb
  begin
    msg_data_o      = {{(fill_width_lp - data_width_lp){1'b0}}, msg_data_i};
    msg_v_o         = msg_v_i;
    msg_ready_and_o = msg_ready_and_i;
    if (pack_i && hold_v_r)
    begin
      // odd word completes the pair, held even word goes in the low half
      msg_data_o = {msg_data_i, hold_data_r};
    end
    else if (pack_i && !last_i)
    begin
      // even word with a partner still to come is only parked
      msg_v_o         = 1'b0;
      msg_ready_and_o = 1'b1;
    end
  end

  // an empty holding register can always take an even word
  assign hold_load  = pack_i && !hold_v_r && !last_i && msg_v_i && msg_ready_and_o;
  assign hold_clear = hold_v_r && msg_v_i && msg_ready_and_o;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      hold_v_r <= 1'b0;
    else if (hold_load)
      hold_v_r <= 1'b1;
    else if (hold_clear)
      hold_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (hold_load)
      hold_data_r <= msg_data_i;
  end

endmodule

// ==== verilog/bp_stream_pump_out.sv ====
////////////////////////////////////////////////////////////
// stream output pump
// turns FSM words into output stream beats, choosing N:1
// or 1:1 forwarding from the configured stream masks
////////////////////////////////////////////////////////////

module bp_stream_pump_out
  import bp_stream_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,

  input  stream_cfg_s               cfg_i,

  // FSM side, header held through the beat marked last
  input  stream_header_s            fsm_header_i,
  input  logic [data_width_lp-1:0]  fsm_data_i,
  input  logic                      fsm_v_i,
  output logic                      fsm_ready_then_o,
  output logic [paddr_width_lp-1:0] fsm_addr_o,
  output logic                      fsm_new_o,
  output logic                      fsm_last_o,
  output logic                      fsm_critical_o,

  // output stream
  output stream_header_s            msg_header_o,
  output logic [fill_width_lp-1:0]  msg_data_o,
  output logic                      msg_v_o,
  input  logic                      msg_ready_and_i
);

  logic gb_v_li;
  logic gb_ready_and_lo;
  logic cnt_up;
  logic nz_stream;
  logic fsm_stream;
  logic msg_stream;

  // more than one FSM beat only above 8 bytes
  assign nz_stream  = (fsm_header_i.size > e_size_8);
  assign fsm_stream = cfg_i.fsm_stream_mask[fsm_header_i.msg_type];
  assign msg_stream = cfg_i.msg_stream_mask[fsm_header_i.msg_type];

  always_comb
  begin
    fsm_ready_then_o = gb_ready_and_lo;
    // every word taken from the FSM advances the counter, in either mode
    cnt_up           = fsm_v_i && fsm_ready_then_o;
    if (fsm_stream && !msg_stream && nz_stream)
    begin
      // N:1, only the first word goes out and the rest are soaked up
      gb_v_li = fsm_v_i && fsm_new_o;
    end
    else
    begin
      // 1:1, every word is handed to the gearbox
      gb_v_li = fsm_v_i;
    end
  end

  bp_stream_pump_control pump_control0
  (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .header_i   (fsm_header_i),
    .ack_i      (cnt_up),
    .addr_o     (fsm_addr_o),
    .first_o    (fsm_new_o),
    .last_o     (fsm_last_o),
    .critical_o (fsm_critical_o)
  );

  bp_stream_gearbox gearbox0
  (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .msg_header_i    (fsm_header_i),
    .msg_data_i      (fsm_data_i),
    .msg_v_i         (gb_v_li),
    .pack_i          (msg_stream),
    .last_i          (fsm_last_o),
    .msg_ready_and_o (gb_ready_and_lo),
    .msg_header_o    (msg_header_o),
    .msg_data_o      (msg_data_o),
    .msg_v_o         (msg_v_o),
    .msg_ready_and_i (msg_ready_and_i)
  );

endmodule

// ==== verilog/bp_stream_out_top.sv ====
////////////////////////////////////////////////////////////
// stream output subsystem top level
// joins the stream configuration register and the pump
////////////////////////////////////////////////////////////

module bp_stream_out_top
  import bp_stream_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,

  // configuration write port
  input  logic                      cfg_w_v_i,
  input  stream_cfg_s               cfg_i,

  // FSM side
  input  stream_header_s            fsm_header_i,
  input  logic [data_width_lp-1:0]  fsm_data_i,
  input  logic                      fsm_v_i,
  output logic                      fsm_ready_then_o,
  output logic [paddr_width_lp-1:0] fsm_addr_o,
  output logic                      fsm_new_o,
  output logic                      fsm_last_o,
  output logic                      fsm_critical_o,

  // output stream
  output stream_header_s            msg_header_o,
  output logic [fill_width_lp-1:0]  msg_data_o,
  output logic                      msg_v_o,
  input  logic                      msg_ready_and_i
);

  stream_cfg_s cfg_lo;

  bp_stream_cfg_regs cfg_regs0
  (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .cfg_w_v_i (cfg_w_v_i),
    .cfg_i     (cfg_i),
    .cfg_o     (cfg_lo)
  );

  bp_stream_pump_out pump0
  (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .cfg_i            (cfg_lo),
    .fsm_header_i     (fsm_header_i),
    .fsm_data_i       (fsm_data_i),
    .fsm_v_i          (fsm_v_i),
    .fsm_ready_then_o (fsm_ready_then_o),
    .fsm_addr_o       (fsm_addr_o),
    .fsm_new_o        (fsm_new_o),
    .fsm_last_o       (fsm_last_o),
    .fsm_critical_o   (fsm_critical_o),
    .msg_header_o     (msg_header_o),
    .msg_data_o       (msg_data_o),
    .msg_v_o          (msg_v_o),
    .msg_ready_and_i  (msg_ready_and_i)
  );

endmodule

// ==== tests/tb_clock_gen.sv ====
////////////////////////////////////////////////////////////
// testbench clock and reset
// period 4 clock, reset held low for the first 5 cycles
////////////////////////////////////////////////////////////

module tb_clock_gen
(
  output logic clk_o,
  output logic arst_n_o
);

  localparam int half_period_lp  = 2;
  localparam int reset_cycles_lp = 5;

  initial
  begin
    clk_o = 1'b0;
    forever #half_period_lp clk_o = ~clk_o;
  end

  // release just after an edge so no flop sees reset and clock together
  initial
  begin
    arst_n_o = 1'b0;
    repeat (reset_cycles_lp) @(posedge clk_o);
    #1;
    arst_n_o = 1'b1;
  end

endmodule

// ==== tests/bp_stream_out_assertions.sv ====
////////////////////////////////////////////////////////////
// stream output protocol assertions
// bound to the top level, watches the FSM and output ports
////////////////////////////////////////////////////////////

module bp_stream_out_assertions
  import bp_stream_pkg::*;
(
  input logic                      clk_i,
  input logic                      arst_n_i,
  input logic                      fsm_v_i,
  input logic                      fsm_ready_i,
  input logic [paddr_width_lp-1:0] fsm_addr_i,
  input logic                      fsm_new_i,
  input logic                      fsm_last_i,
  input stream_header_s            msg_header_i,
  input logic [fill_width_lp-1:0]  msg_data_i,
  input logic                      msg_v_i,
  input logic                      msg_ready_i
);

  // number of assertion failures so far, read by the testbench top
  int fail_cnt = 0;

  // a stalled output beat keeps valid, data and header until the sink takes it
  hold_under_stall: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    msg_v_i && !msg_ready_i |=> msg_v_i && $stable(msg_data_i) && $stable(msg_header_i))
  else
  begin
    $error("output beat changed while the sink was stalling it");
    fail_cnt++;
  end

  // nothing leaves the pump while reset is held
  quiet_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !msg_v_i)
  else
  begin
    $error("msg_v_o high during reset");
    fail_cnt++;
  end

  // taking the last beat brings the counter back to the first beat
  new_after_last: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    fsm_v_i && fsm_ready_i && fsm_last_i |=> fsm_new_i)
  else
  begin
    $error("fsm_new_o not high after the last beat was taken");
    fail_cnt++;
  end

  // within a message each taken beat moves the address up one word
  addr_step: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    fsm_v_i && fsm_ready_i && !fsm_last_i |=>
      fsm_addr_i == $past(fsm_addr_i) + paddr_width_lp'(8))
  else
  begin
    $error("fsm_addr_o did not step by 8 within a message");
    fail_cnt++;
  end

endmodule

// ==== tests/tb_stream_out.sv ====
////////////////////////////////////////////////////////////
// stream output testbench
// FSM model, sink with optional random ready, a reference
// model of the output beats and a per-test report
////////////////////////////////////////////////////////////

module tb_stream_out
  import bp_stream_pkg::*;
();

  // about 55 FSM beats in all, each a few cycles at worst with random ready
  localparam int timeout_cycles_lp = 4000;
  // writes pack on the output, reads and writes stream on the FSM side
  localparam stream_cfg_s default_cfg_lp = '{msg_stream_mask: 4'b1010, fsm_stream_mask: 4'b0011};

  logic                      clk;
  logic                      arst_n;
  logic                      cfg_w_v;
  stream_cfg_s               cfg;
  stream_header_s            fsm_header;
  logic [data_width_lp-1:0]  fsm_data;
  logic                      fsm_v;
  logic                      fsm_ready_then;
  logic [paddr_width_lp-1:0] fsm_addr;
  logic                      fsm_new;
  logic                      fsm_last;
  logic                      fsm_critical;
  stream_header_s            msg_header;
  logic [fill_width_lp-1:0]  msg_data;
  logic                      msg_v;
  logic                      msg_ready_and;

  logic [31:0]               rng_state;
  logic                      random_ready;
  stream_cfg_s               cfg_model;
  logic [fill_width_lp-1:0]  exp_q[$];
  int                        check_errors;
  int                        errors_at_start;
  int                        tests_ok;
  int                        tests_bad;
  int                        cycle_cnt = 0;

  tb_clock_gen clock0 (.clk_o(clk), .arst_n_o(arst_n));

  bp_stream_out_top dut0
  (
    .clk_i            (clk),
    .arst_n_i         (arst_n),
    .cfg_w_v_i        (cfg_w_v),
    .cfg_i            (cfg),
    .fsm_header_i     (fsm_header),
    .fsm_data_i       (fsm_data),
    .fsm_v_i          (fsm_v),
    .fsm_ready_then_o (fsm_ready_then),
    .fsm_addr_o       (fsm_addr),
    .fsm_new_o        (fsm_new),
    .fsm_last_o       (fsm_last),
    .fsm_critical_o   (fsm_critical),
    .msg_header_o     (msg_header),
    .msg_data_o       (msg_data),
    .msg_v_o          (msg_v),
    .msg_ready_and_i  (msg_ready_and)
  );

  bind bp_stream_out_top bp_stream_out_assertions assertions0
  (
    .clk_i (clk_i), .arst_n_i (arst_n_i), .fsm_v_i (fsm_v_i),
    .fsm_ready_i (fsm_ready_then_o), .fsm_addr_i (fsm_addr_o),
    .fsm_new_i (fsm_new_o), .fsm_last_i (fsm_last_o),
    .msg_header_i (msg_header_o), .msg_data_i (msg_data_o),
    .msg_v_i (msg_v_o), .msg_ready_i (msg_ready_and_i)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = lcg_next(rng_state);
    return rng_state;
  endfunction

  // one FSM beat per 8 bytes, never fewer than one
  function automatic int beat_count(input msg_size_e size);
    int bytes;
    bytes = 1 << size;
    return (bytes < 8) ? 1 : bytes / 8;
  endfunction

  function automatic int total_errors();
    return check_errors + dut0.assertions0.fail_cnt;
  endfunction

  task automatic report_mismatch(input string what);
    $display("Fail at %0t: %s", $time, what);
    check_errors++;
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = total_errors() - errors_at_start;
    if (errs == 0)
      tests_ok++;
    else
      tests_bad++;
    $display("test %s: %0d errors", name, errs);
    errors_at_start = total_errors();
  endtask

  task automatic write_cfg(input stream_cfg_s value);
    @(posedge clk);
    #1;
    cfg     = value;
    cfg_w_v = 1'b1;
    @(posedge clk);
    #1;
    cfg_w_v   = 1'b0;
    cfg_model = value;
  endtask

  // drives one message and checks every FSM beat and output beat against the rules
  task automatic send_message(input msg_type_e t, input msg_size_e size,
                              input logic [paddr_width_lp-1:0] addr);
    stream_header_s            hdr;
    logic [data_width_lp-1:0]  words[8];
    logic [paddr_width_lp-1:0] base;
    logic [fill_width_lp-1:0]  exp_beat;
    logic [31:0]               hi;
    logic [31:0]               lo;
    int                        n;
    int                        i;
    int                        sent;
    int                        crit;
    int                        bytes;
    hdr   = '{msg_type: t, size: size, addr: addr};
    n     = beat_count(size);
    // the first beat sits at the address rounded down to a whole message
    bytes = 1 << size;
    base  = addr - paddr_width_lp'(int'(addr) % bytes);
    crit  = int'(addr[5:3]) % n;
    for (i = 0; i < n; i++)
    begin
      hi       = next_random();
      lo       = next_random();
      words[i] = {hi, lo};
    end
    // expected output: N:1 sends word 0 alone, packing pairs words, else one word per beat
    if (cfg_model.fsm_stream_mask[t] && !cfg_model.msg_stream_mask[t] && n > 1)
      exp_q.push_back({64'd0, words[0]});
    else if (cfg_model.msg_stream_mask[t])
      for (i = 0; i < n; i += 2)
        exp_q.push_back((i + 1 < n) ? {words[i+1], words[i]} : {64'd0, words[i]});
    else
      for (i = 0; i < n; i++)
        exp_q.push_back({64'd0, words[i]});
    sent = 0;
    while (sent < n)
    begin
      @(posedge clk);
      #1;
      fsm_v         = 1'b0;
      fsm_header    = hdr;
      fsm_data      = words[sent];
      lo            = next_random();
      msg_ready_and = random_ready ? lo[16] : 1'b1;
      // ready-then, valid only once ready is seen in this cycle
      #1;
      fsm_v = fsm_ready_then;
      #1;
      if (msg_v && msg_ready_and)
      begin
        if (exp_q.size() == 0)
        begin
          $display("Error: the DUT sent an output beat that was not expected");
          check_errors++;
        end
        else
        begin
          exp_beat = exp_q.pop_front();
          assert (msg_data == exp_beat) else report_mismatch("msg_data_o differs");
          assert (msg_header == hdr) else report_mismatch("msg_header_o differs");
        end
      end
      if (fsm_v && fsm_ready_then)
      begin
        assert (fsm_addr == base + paddr_width_lp'(8 * sent))
          else report_mismatch("fsm_addr_o wrong");
        assert (fsm_new == (sent == 0)) else report_mismatch("fsm_new_o wrong");
        assert (fsm_last == (sent == n - 1)) else report_mismatch("fsm_last_o wrong");
        assert (fsm_critical == (sent == crit)) else report_mismatch("fsm_critical_o wrong");
        sent++;
      end
    end
    @(posedge clk);
    #1;
    fsm_v = 1'b0;
    if (exp_q.size() != 0)
    begin
      $display("Error: %0d expected output beats never appeared", exp_q.size());
      check_errors++;
      exp_q.delete();
    end
  endtask

  // ends the run if the tests stall
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == timeout_cycles_lp)
    begin
      $display("Error: the run hung, still busy after %0d cycles", timeout_cycles_lp);
      $display("Verification failed");
      $finish;
    end
  end

  initial
  begin
    rng_state       = 32'h3f7f54e8;
    random_ready    = 1'b0;
    cfg_model       = default_cfg_lp;
    check_errors    = 0;
    errors_at_start = 0;
    tests_ok        = 0;
    tests_bad       = 0;
    cfg_w_v         = 1'b0;
    cfg             = default_cfg_lp;
    fsm_header      = '0;
    fsm_data        = '0;
    fsm_v           = 1'b0;
    msg_ready_and   = 1'b1;
    @(posedge arst_n);
    repeat (2) @(posedge clk);
    assert (fsm_new) else report_mismatch("fsm_new_o low after reset");

    send_message(e_wr, e_size_64, 16'h0400);
    end_test("1 packed 64-byte write");
    send_message(e_rd, e_size_64, 16'h0840);
    end_test("2 N:1 64-byte read");
    // word offset 6 makes beat 2 critical in a 4-beat message
    send_message(e_uc_rd, e_size_32, 16'h1270);
    end_test("3 address and flags");
    send_message(e_uc_wr, e_size_8, 16'h2008);
    send_message(e_uc_rd, e_size_16, 16'h2010);
    end_test("4 single and unpacked beats");
    // both e_wr bits cleared, so a write goes out one word per beat
    write_cfg('{msg_stream_mask: 4'b1000, fsm_stream_mask: 4'b0001});
    send_message(e_wr, e_size_64, 16'h3000);
    end_test("5 unpacked write after config change");
    write_cfg(default_cfg_lp);
    random_ready = 1'b1;
    repeat (2)
    begin
      send_message(e_wr, e_size_64, 16'h4040);
      send_message(e_uc_wr, e_size_8, 16'h4108);
      send_message(e_uc_rd, e_size_16, 16'h4210);
    end
    end_test("6 random sink ready");

    $display("tests: %0d ok, %0d with errors", tests_ok, tests_bad);
    if (tests_bad == 0 && total_errors() == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

// ==== bp_stream_out.f ====
verilog/bp_stream_pkg.sv
verilog/bp_stream_cfg_regs.sv
verilog/bp_stream_pump_control.sv
verilog/bp_stream_gearbox.sv
verilog/bp_stream_pump_out.sv
verilog/bp_stream_out_top.sv
tests/tb_clock_gen.sv
tests/bp_stream_out_assertions.sv
tests/tb_stream_out.sv
